// ==== verilog/seg_pkg.sv ====
package seg_pkg;

    // display geometry
    localparam int NUM_DIGITS = 8;
    localparam int DIGIT_W    = 3;                       // index for NUM_DIGITS digits
    localparam int NIBBLE_W   = 4;
    localparam int DATA_W     = NUM_DIGITS * NIBBLE_W;   // one nibble per digit
    localparam int SEG_W      = 7;                       // segments a..g, no point

    // scan pacing, about 50000 on a 100 MHz board
    localparam int SCAN_DIV   = 16;
    localparam int SCAN_CNT_W = $clog2(SCAN_DIV);

    // sequencer states
    typedef enum logic [0:0] {
        BLANK = 1'b0,                                    // all anodes off
        SHOW  = 1'b1                                     // addressed digit lit
    } seq_state_t;

    // glyphs, active low, bit order g..a
    localparam logic [SEG_W-1:0] GLYPH_0   = 7'b1000000;
    localparam logic [SEG_W-1:0] GLYPH_1   = 7'b1111001;
    localparam logic [SEG_W-1:0] GLYPH_2   = 7'b0100100;
    localparam logic [SEG_W-1:0] GLYPH_3   = 7'b0110000;
    localparam logic [SEG_W-1:0] GLYPH_4   = 7'b0011001;
    localparam logic [SEG_W-1:0] GLYPH_5   = 7'b0010010;
    localparam logic [SEG_W-1:0] GLYPH_6   = 7'b0000010;
    localparam logic [SEG_W-1:0] GLYPH_7   = 7'b1111000;
    localparam logic [SEG_W-1:0] GLYPH_8   = 7'b0000000;
    localparam logic [SEG_W-1:0] GLYPH_9   = 7'b0010000;
    localparam logic [SEG_W-1:0] GLYPH_OFF = 7'b1111111; // nibbles A..F stay dark

endpackage

// ==== verilog/scan_timer.sv ====
`timescale 1ns/1ps

module scan_timer (
    input  logic clock,
    input  logic rst,
    output logic tick
);

    import seg_pkg::*;

    logic [SCAN_CNT_W-1:0] cnt;
    logic                  wrap;

    assign wrap = (cnt == SCAN_CNT_W'(SCAN_DIV - 1));

    // free-running prescaler
    always_ff @(posedge clock) begin
        if (rst) begin
            cnt <= '0;
        end else if (wrap) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + SCAN_CNT_W'(1);
        end
    end

    // registered so the first tick lands SCAN_DIV cycles after reset
    always_ff @(posedge clock) begin
        if (rst) begin
            tick <= 1'b0;
        end else begin
            tick <= wrap;
        end
    end

    // tick is a single-cycle pulse
    a_tick_single: assert property (
        @(posedge clock) disable iff (rst)
        tick |=> !tick
    );

endmodule

// ==== verilog/digit_sequencer.sv ====
`timescale 1ns/1ps

module digit_sequencer (
    input  logic                        clock,
    input  logic                        rst,
    input  logic                        tick,
    output logic [seg_pkg::DIGIT_W-1:0] digit,
    output logic                        show
);

    import seg_pkg::*;

    seq_state_t state;
    seq_state_t state_nxt;
    logic       advance;

    // leaving SHOW moves on to the next digit
    assign advance = tick && (state == SHOW);

    always_comb begin
        state_nxt = state;
        if (tick) begin
            case (state)
                BLANK:   state_nxt = SHOW;
                SHOW:    state_nxt = BLANK;
                default: state_nxt = BLANK;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= BLANK;
            show  <= 1'b0;
        end else begin
            state <= state_nxt;
            show  <= (state_nxt == SHOW);    // kept as a flop, no decode glitch
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            digit <= '0;
        end else if (advance) begin
            digit <= digit + DIGIT_W'(1);    // wraps 7 -> 0
        end
    end

    // digit moves only on the edge that closes a SHOW window
    a_digit_step: assert property (
        @(posedge clock) disable iff (rst)
        $changed(digit) |-> $past(advance)
    );

    // show flop tracks the state register
    a_show_state: assert property (
        @(posedge clock) disable iff (rst)
        show == (state == SHOW)
    );

endmodule

// ==== verilog/digit_mux.sv ====
`timescale 1ns/1ps

module digit_mux (
    input  logic                           clock,
    input  logic                           rst,
    input  logic [seg_pkg::DATA_W-1:0]     data,
    input  logic [seg_pkg::NUM_DIGITS-1:0] dp,
    input  logic                           load,
    input  logic [seg_pkg::DIGIT_W-1:0]    digit,
    input  logic                           show,
    output logic [seg_pkg::NIBBLE_W-1:0]   nibble,
    input  logic [seg_pkg::SEG_W-1:0]      segs,
    output logic [seg_pkg::SEG_W:0]        ca,
    output logic [seg_pkg::NUM_DIGITS-1:0] an
);

    import seg_pkg::*;

    logic [DATA_W-1:0]     value_q;
    logic [NUM_DIGITS-1:0] dp_q;
    logic                  point;

    // held value, shown as zeros until the first load
    always_ff @(posedge clock) begin
        if (rst) begin
            value_q <= '0;
            dp_q    <= '0;
        end else if (load) begin
            value_q <= data;
            dp_q    <= dp;
        end
    end

    // addressed nibble goes out to the decoder
    assign nibble = value_q[digit * NIBBLE_W +: NIBBLE_W];
    assign point  = dp_q[digit];

    always_ff @(posedge clock) begin
        if (rst) begin
            ca <= '1;
            an <= '1;
        end else if (show) begin
            ca <= {~point, segs};                       // point active low
            an <= ~(NUM_DIGITS'(1) << digit);           // one anode pulled low
        end else begin
            ca <= '1;
            an <= '1;
        end
    end

    // never two digits driven at once
    a_an_onehot: assert property (
        @(posedge clock) disable iff (rst)
        $onehot0(~an)
    );

endmodule

// ==== verilog/seg_decoder.sv ====
`timescale 1ns/1ps

module seg_decoder (
    input  logic [seg_pkg::NIBBLE_W-1:0] nibble,
    output logic [seg_pkg::SEG_W-1:0]    segs
);

    import seg_pkg::*;

    // decimal glyphs only, hex codes blank the digit
    always_comb begin
        case (nibble)
            4'h0:    segs = GLYPH_0;
            4'h1:    segs = GLYPH_1;
            4'h2:    segs = GLYPH_2;
            4'h3:    segs = GLYPH_3;
            4'h4:    segs = GLYPH_4;
            4'h5:    segs = GLYPH_5;
            4'h6:    segs = GLYPH_6;
            4'h7:    segs = GLYPH_7;
            4'h8:    segs = GLYPH_8;
            4'h9:    segs = GLYPH_9;
            default: segs = GLYPH_OFF;    // A..F
        endcase
    end

endmodule

// ==== verilog/seven_segment_display.sv ====
`timescale 1ns/1ps

module seven_segment_display (
    input  logic                           clock,
    input  logic                           rst,
    input  logic [seg_pkg::DATA_W-1:0]     data,
    input  logic [seg_pkg::NUM_DIGITS-1:0] dp,
    input  logic                           load,
    output logic [seg_pkg::SEG_W:0]        ca,
    output logic [seg_pkg::NUM_DIGITS-1:0] an
);

    import seg_pkg::*;

    logic                tick;
    logic [DIGIT_W-1:0]  digit;
    logic                show;
    logic [NIBBLE_W-1:0] nibble;
    logic [SEG_W-1:0]    segs;

    scan_timer i_scan_timer (
        .clock (clock),
        .rst   (rst),
        .tick  (tick)
    );

    digit_sequencer i_digit_sequencer (
        .clock (clock),
        .rst   (rst),
        .tick  (tick),
        .digit (digit),
        .show  (show)
    );

    // value register and registered pin drivers
    digit_mux i_digit_mux (
        .clock  (clock),
        .rst    (rst),
        .data   (data),
        .dp     (dp),
        .load   (load),
        .digit  (digit),
        .show   (show),
        .nibble (nibble),
        .segs   (segs),
        .ca     (ca),
        .an     (an)
    );

    seg_decoder i_seg_decoder (
        .nibble (nibble),
        .segs   (segs)
    );

endmodule

// ==== verification/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
    output logic clock,
    output logic rst
);

    // 10 ns period
    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // reset held over 16 rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clock);
        @(negedge clock);
        rst <= 1'b0;
    end

endmodule

// ==== verification/tb_seven_segment_display.sv ====
`timescale 1ns/1ps

module tb_seven_segment_display;

    import seg_pkg::*;

    logic                  clock;
    logic                  rst;
    logic [DATA_W-1:0]     data;
    logic [NUM_DIGITS-1:0] dp;
    logic                  load;
    logic [7:0]            ca;
    logic [NUM_DIGITS-1:0] an;

    logic [31:0] model_value;    // what the outputs reflect now
    logic [7:0]  model_dp;
    logic [31:0] pend_value;
    logic [7:0]  pend_dp;
    int          commit_in;
    int          next_digit;
    integer      seed;
    int          cycle_cnt = 0;
    // scan periods per test: reset 1, order 2, decimal 3, blank 2, reload 2
    int          cycle_limit = (1 + 2 + 3 + 2 + 2) * 2 * NUM_DIGITS * SCAN_DIV + 128;

    clock_gen i_clock_gen (
        .clock (clock),
        .rst   (rst)
    );

    seven_segment_display i_dut (
        .clock (clock),
        .rst   (rst),
        .data  (data),
        .dp    (dp),
        .load  (load),
        .ca    (ca),
        .an    (an)
    );

    always @(posedge clock) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("Simulation failed");
            $fatal(1, "run timed out after %0d cycles", cycle_cnt);
        end
    end

    // active low, bit order g..a
    function automatic logic [6:0] expected_glyph(input logic [3:0] nib);
        case (nib)
            4'd0:    return 7'b1000000;
            4'd1:    return 7'b1111001;
            4'd2:    return 7'b0100100;
            4'd3:    return 7'b0110000;
            4'd4:    return 7'b0011001;
            4'd5:    return 7'b0010010;
            4'd6:    return 7'b0000010;
            4'd7:    return 7'b1111000;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0010000;
            default: return 7'b1111111;    // A..F dark
        endcase
    endfunction

    function automatic logic [7:0] expected_ca(input int d);
        return {~model_dp[d], expected_glyph(model_value[d * 4 +: 4])};
    endfunction

    // all anodes off except the addressed one
    function automatic logic [7:0] expected_an(input int d);
        logic [7:0] pattern;
        pattern    = 8'hff;
        pattern[d] = 1'b0;
        return pattern;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "%s check failed", name);
        end
    endtask

    task automatic random_decimal(output logic [31:0] value);
        for (int i = 0; i < NUM_DIGITS; i++) begin
            value[i * 4 +: 4] = 4'($unsigned($random(seed)) % 10);
        end
    endtask

    // one falling edge, where outputs are sampled and inputs driven
    task automatic step();
        @(negedge clock);
        load = 1'b0;
        if (commit_in > 0) begin
            commit_in--;
            if (commit_in == 0) begin
                model_value = pend_value;
                model_dp    = pend_dp;
            end
        end
    endtask

    // stored on the next edge, visible from the output update after that
    task automatic load_value(input logic [31:0] value, input logic [7:0] points);
        data       = value;
        dp         = points;
        load       = 1'b1;
        pend_value = value;
        pend_dp    = points;
        commit_in  = 2;
    endtask

    task automatic scan_window(input int reload_at, input logic [31:0] value,
                               input logic [7:0] points);
        for (int i = 0; i < SCAN_DIV; i++) begin
            check_value("an", 32'(expected_an(next_digit)), 32'(an));
            check_value("ca", 32'(expected_ca(next_digit)), 32'(ca));
            if (i == reload_at) begin
                load_value(value, points);
            end
            step();
        end
        check_value("an after window", 32'hff, 32'(an));
        next_digit = (next_digit + 1) % NUM_DIGITS;
    endtask

    task automatic check_gap(input int expected_len);
        int len;
        len = 0;
        while (an == 8'hff) begin
            check_value("ca in gap", 32'hff, 32'(ca));
            len++;
            step();
        end
        check_value("gap length", 32'(expected_len), 32'(len));
    endtask

    task automatic scan_digits(input int count);
        repeat (count) begin
            scan_window(-1, '0, '0);
            check_gap(SCAN_DIV);
        end
    endtask

    // new value goes in during the gap after the current window
    task automatic show_and_load(input logic [31:0] value, input logic [7:0] points);
        scan_window(-1, '0, '0);
        load_value(value, points);
        check_gap(SCAN_DIV);
    endtask

    task automatic test_reset();
        step();
        while (rst === 1'b1) begin
            check_value("an in reset", 32'hff, 32'(an));
            check_value("ca in reset", 32'hff, 32'(ca));
            step();
        end
        check_gap(SCAN_DIV + 1);    // tick, state, then the output register
    endtask

    task automatic test_scan_order();
        scan_digits(2 * NUM_DIGITS);    // two rounds to see the wrap
    endtask

    task automatic test_decimal();
        logic [31:0] value;
        logic [7:0]  points;
        show_and_load(32'h7654_3210, 8'ha5);
        scan_digits(NUM_DIGITS - 1);
        repeat (2) begin
            random_decimal(value);
            points = 8'($random(seed));
            show_and_load(value, points);
            scan_digits(NUM_DIGITS - 1);
        end
    endtask

    task automatic test_blank_codes();
        show_and_load(32'hA1B2_C3FD, 8'hff);    // points stay lit on dark digits
        scan_digits(NUM_DIGITS - 1);
        show_and_load(32'hFEDC_BA98, 8'h3c);
        scan_digits(NUM_DIGITS - 1);
    endtask

    task automatic test_reload();
        logic [31:0] value;
        random_decimal(value);
        // every point bit flips so the switch shows mid window
        scan_window(SCAN_DIV / 2, value, 8'hc3);
        check_gap(SCAN_DIV);
        scan_digits(NUM_DIGITS);
    endtask

    initial begin
        data        = '0;
        dp          = '0;
        load        = 1'b0;
        model_value = '0;
        model_dp    = '0;
        pend_value  = '0;
        pend_dp     = '0;
        commit_in   = 0;
        next_digit  = 0;
        seed        = 32'h526f_1794;
        test_reset();
        test_scan_order();
        test_decimal();
        test_blank_codes();
        test_reload();
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== filelist.f ====
verilog/seg_pkg.sv
verilog/scan_timer.sv
verilog/digit_sequencer.sv
verilog/digit_mux.sv
verilog/seg_decoder.sv
verilog/seven_segment_display.sv
verification/clock_gen.sv
verification/tb_seven_segment_display.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the display driver testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f filelist.f --top-module tb_seven_segment_display -o sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
echo "pass message not found"
exit 1
